// File: lsu.f
lsu_pkg.sv
lsu_addr_gen.sv
lsu_txn_ctrl.sv
lsu_wb_fifo.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu.sv

// File: lsu_addr_gen.sv
// load/store address generation
`default_nettype none
`timescale 1ns/1ps

module lsu_addr_gen (
  input  wire logic                        clk,             // sampling clock of the check
  input  wire logic                        valid_i,         // request valid from execute
  input  wire logic [lsu_pkg::XLEN-1:0]    operand_a_i,     // base address
  input  wire logic [lsu_pkg::XLEN-1:0]    operand_b_i,     // offset
  input  wire logic                        addr_useincr_i,  // a + b when set, else a
  input  wire logic [1:0]                  dtype_i,         // access size
  input  wire logic [lsu_pkg::XLEN-1:0]    wdata_i,         // store data as in register
  input  wire logic [lsu_pkg::OFFS_W-1:0]  reg_offset_i,    // byte offset inside register
  output logic      [lsu_pkg::XLEN-1:0]    addr_o,
  output logic      [lsu_pkg::BE_W-1:0]    be_o,
  output logic      [lsu_pkg::XLEN-1:0]    wdata_o
);

  logic [lsu_pkg::OFFS_W-1:0] addr_offs;   // low address bits
  logic [lsu_pkg::OFFS_W-1:0] rot_offs;    // lanes to rotate store data by
  logic [lsu_pkg::BE_W-1:0]   be_base;     // enables before shifting to the offset
  logic                       aligned;

  // address adder, plain a for post-increment forms
  assign addr_o    = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_offs = addr_o[lsu_pkg::OFFS_W-1:0];

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    case (dtype_i)
      lsu_pkg::DT_WORD: be_base = 4'b1111;
      lsu_pkg::DT_HALF: be_base = 4'b0011;
      default:          be_base = 4'b0001;  // both byte codes
    endcase
  end

  assign be_o = be_base << addr_offs;  // move enables to the addressed lanes

  ////////////////////
  // store data
  ////////////////////

  // register lane vs memory lane, wraps mod 4
  assign rot_offs = addr_offs - reg_offset_i;

  always_comb begin
    case (rot_offs)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};  // rotate left one byte
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // words on 4-byte, halfwords on 2-byte boundaries
  always_comb begin
    case (dtype_i)
      lsu_pkg::DT_WORD: aligned = (addr_offs == 2'b00);
      lsu_pkg::DT_HALF: aligned = (addr_offs[0] == 1'b0);
      default:          aligned = 1'b1;
    endcase
  end

  // misaligned accesses would need a second bus phase, not supported
  a_natural_align : assert property (@(posedge clk) valid_i |-> aligned)
    else $error("misaligned access addr=%h type=%b", addr_o, dtype_i);

endmodule

`default_nettype wire

// File: lsu_load_align.sv
// load data alignment and extension
`default_nettype none
`timescale 1ns/1ps

module lsu_load_align (
  input  wire logic [lsu_pkg::XLEN-1:0] rdata_i,  // raw bus word
  input  wire lsu_pkg::wb_ctrl_t        ctrl_i,   // head of writeback queue
  output logic      [lsu_pkg::XLEN-1:0] rdata_o   // register file value
);

  logic [lsu_pkg::XLEN-1:0] shifted;   // addressed lane moved to bit 0
  logic                     half_msb;
  logic                     byte_msb;
  logic [15:0]              half_fill;
  logic [23:0]              byte_fill;

  // drop the lanes below the access
  assign shifted  = rdata_i >> {ctrl_i.offs, 3'b000};
  assign half_msb = shifted[15];
  assign byte_msb = shifted[7];

  ////////////////////
  // upper bit fill
  ////////////////////

  always_comb begin
    case (ctrl_i.ext)
      lsu_pkg::EXT_ZERO: begin
        half_fill = '0;
        byte_fill = '0;
      end
      lsu_pkg::EXT_ONES: begin
        half_fill = '1;
        byte_fill = '1;
      end
      default: begin  // sign, also the unused code
        half_fill = {16{half_msb}};
        byte_fill = {24{byte_msb}};
      end
    endcase
  end

  ////////////////////
  // size select
  ////////////////////

  always_comb begin
    case (ctrl_i.dtype)
      lsu_pkg::DT_WORD: rdata_o = rdata_i;                     // aligned word as is
      lsu_pkg::DT_HALF: rdata_o = {half_fill, shifted[15:0]};
      default:          rdata_o = {byte_fill, shifted[7:0]};   // 10 and 11
    endcase
  end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
// load/store unit shared types
`default_nettype none

package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int XLEN   = 32;        // data and address width
  localparam int BE_W   = XLEN / 8;  // one enable per byte lane
  localparam int OFFS_W = 2;         // byte offset inside a word

  ////////////////////
  // encodings
  ////////////////////

  // access size as driven by the execute stage
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10   // 2'b11 decodes as a byte as well
  } dtype_e;

  // fill of the upper bits for halfword and byte loads
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } ext_e;

  ////////////////////
  // writeback control
  ////////////////////

  // one entry per outstanding transaction, 7 bits
  typedef struct packed {
    logic              we;     // store, no load data returned
    dtype_e            dtype;  // access size
    ext_e              ext;    // extension mode
    logic [OFFS_W-1:0] offs;   // byte offset of the access
  } wb_ctrl_t;

endpackage

`default_nettype wire

// File: lsu_stimulus.txt
0 0 1 00000ffc 00000024 1 00000000 0 00001020 f 00000000 9c5ae137 9c5ae137
1 0 0 00007000 00000004 1 11223344 0 00007004 f 11223344 00000000 00000000
0 0 0 00002004 00000100 0 00000000 0 00002004 f 00000000 7f802468 7f802468
0 1 0 00003000 00000000 1 00000000 0 00003000 3 00000000 9c5ae137 0000e137
0 1 1 00003000 00000000 0 00000000 0 00003000 3 00000000 9c5ae137 ffffe137
1 1 0 00007000 00000002 1 0000beef 0 00007002 c beef0000 00000000 00000000
0 1 1 00003000 00000002 1 00000000 0 00003002 c 00000000 9c5ae137 ffff9c5a
0 1 0 00003002 00000000 0 00000000 0 00003002 c 00000000 9c5ae137 00009c5a
0 1 2 00003000 00000002 1 00000000 0 00003002 c 00000000 7f802468 ffff7f80
1 2 0 00007000 00000001 1 000000a5 0 00007001 2 0000a500 00000000 00000000
0 1 1 00004000 00000000 0 00000000 0 00004000 3 00000000 7f802468 00002468
0 1 2 00004000 00000000 0 00000000 0 00004000 3 00000000 7f802468 ffff2468
0 2 0 00005000 00000000 0 00000000 0 00005000 1 00000000 9c5ae137 00000037
1 3 0 00007003 00000000 0 000000c3 0 00007003 8 c3000000 00000000 00000000
0 2 1 00005000 00000001 1 00000000 0 00005001 2 00000000 9c5ae137 ffffffe1
0 2 1 00005002 00000000 0 00000000 0 00005002 4 00000000 9c5ae137 0000005a
0 3 0 00005003 00000000 0 00000000 0 00005003 8 00000000 9c5ae137 0000009c
1 2 0 00007000 00000000 0 00d40000 2 00007000 1 000000d4 00000000 00000000
0 3 1 00005000 00000003 1 00000000 0 00005003 8 00000000 9c5ae137 ffffff9c
0 2 2 00006002 00000000 0 00000000 0 00006002 4 00000000 7f802468 ffffff80
0 2 2 00006000 00000001 1 00000000 0 00006001 2 00000000 7f802468 ffffff24
1 1 0 00007008 00000000 0 12345678 2 00007008 3 56781234 00000000 00000000
0 2 1 00006000 00000000 0 00000000 0 00006000 1 00000000 000000f0 fffffff0
0 2 0 00006002 00000000 0 00000000 0 00006002 4 00000000 7f802468 00000080
1 2 0 00007008 00000002 1 0000ab00 1 0000700a 4 00ab0000 00000000 00000000
1 2 0 00007009 00000000 0 7e000000 3 00007009 2 00007e00 00000000 00000000

// File: lsu_top.sv
// load/store unit top level
`default_nettype none
`timescale 1ns/1ps

module lsu_top #(
  parameter int LSU_DEPTH = 2  // max outstanding bus transactions
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // execute stage
  input  wire logic                        data_req_ex_i,
  input  wire logic                        data_we_ex_i,
  input  wire logic [1:0]                  data_type_ex_i,      // 00 word, 01 half, 1x byte
  input  wire logic [1:0]                  data_sign_ext_ex_i,  // 00 zero, 01 sign, 10 ones
  input  wire logic [lsu_pkg::XLEN-1:0]    data_wdata_ex_i,
  input  wire logic [lsu_pkg::OFFS_W-1:0]  data_reg_offset_ex_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    operand_a_ex_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    operand_b_ex_i,
  input  wire logic                        addr_useincr_ex_i,

  // data bus
  output logic                             data_req_o,
  input  wire logic                        data_gnt_i,
  output logic      [lsu_pkg::XLEN-1:0]    data_addr_o,
  output logic                             data_we_o,
  output logic      [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic      [lsu_pkg::XLEN-1:0]    data_wdata_o,
  input  wire logic                        data_rvalid_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    data_rdata_i,

  // pipeline handshake and results
  output logic                             lsu_ready_ex_o,
  output logic                             lsu_ready_wb_o,
  output logic                             busy_o,
  output logic      [lsu_pkg::XLEN-1:0]    data_rdata_ex_o,
  output logic                             data_rvalid_ex_o
);

  logic              push;        // accepted on the bus
  logic              fifo_full;
  lsu_pkg::wb_ctrl_t wb_entry;    // control of the access being issued
  lsu_pkg::wb_ctrl_t wb_head;     // control of the oldest outstanding one

  assign data_we_o = data_we_ex_i;

  // offset taken from the generated address rather than the operands
  assign wb_entry = '{we:    data_we_ex_i,
                      dtype: lsu_pkg::dtype_e'(data_type_ex_i),
                      ext:   lsu_pkg::ext_e'(data_sign_ext_ex_i),
                      offs:  data_addr_o[lsu_pkg::OFFS_W-1:0]};

  // only loads report back to writeback
  assign data_rvalid_ex_o = data_rvalid_i && !wb_head.we;

  ////////////////////
  // submodules
  ////////////////////

  lsu_addr_gen addr_gen_inst (
    .clk            (clk),
    .valid_i        (data_req_ex_i),
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .dtype_i        (data_type_ex_i),
    .wdata_i        (data_wdata_ex_i),
    .reg_offset_i   (data_reg_offset_ex_i),
    .addr_o         (data_addr_o),
    .be_o           (data_be_o),
    .wdata_o        (data_wdata_o)
  );

  lsu_txn_ctrl #(.DEPTH(LSU_DEPTH)) txn_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_ex_i    (data_req_ex_i),
    .gnt_i       (data_gnt_i),
    .rvalid_i    (data_rvalid_i),
    .fifo_full_i (fifo_full),
    .req_o       (data_req_o),
    .push_o      (push),
    .ready_ex_o  (lsu_ready_ex_o),
    .ready_wb_o  (lsu_ready_wb_o),
    .busy_o      (busy_o)
  );

  lsu_wb_fifo #(.DEPTH(LSU_DEPTH)) wb_fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (push),
    .entry_i (wb_entry),
    .pop_i   (data_rvalid_i),  // responses retire in order
    .head_o  (wb_head),
    .full_o  (fifo_full),
    .empty_o ()
  );

  lsu_load_align load_align_inst (
    .rdata_i (data_rdata_i),
    .ctrl_i  (wb_head),
    .rdata_o (data_rdata_ex_o)
  );

  ////////////////////
  // checks
  ////////////////////

  // stalled address phase keeps request and payload until the grant
  a_req_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o &&
      $stable({data_addr_o, data_we_o, data_be_o, data_wdata_o}))
    else $error("bus request changed before grant");

endmodule

`default_nettype wire

// File: lsu_txn_ctrl.sv
// outstanding transaction control
`default_nettype none
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int DEPTH = 2  // max outstanding bus transactions
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic req_ex_i,     // access pending in execute
  input  wire logic gnt_i,        // bus grant
  input  wire logic rvalid_i,     // bus response
  input  wire logic fifo_full_i,  // no room for another writeback entry
  output logic      req_o,        // bus request
  output logic      push_o,       // request accepted this cycle
  output logic      ready_ex_o,
  output logic      ready_wb_o,
  output logic      busy_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);  // holds 0 .. DEPTH

  logic [CNT_W-1:0] cnt_q;     // outstanding transactions
  logic [CNT_W-1:0] cnt_d;
  logic             cnt_up;
  logic             cnt_down;

  ////////////////////
  // request gating
  ////////////////////

  // request straight from execute as long as there is room, no path from rvalid
  assign req_o  = req_ex_i && (cnt_q < CNT_W'(DEPTH)) && !fifo_full_i;
  assign push_o = req_o && gnt_i;  // address phase done

  // execute may move on once its access is on the bus, or right away if idle
  assign ready_ex_o = !req_ex_i || push_o;

  // writeback waits for the oldest response
  assign ready_wb_o = (cnt_q == '0) || rvalid_i;

  assign busy_o = (cnt_q != '0) || req_o;

  ////////////////////
  // counter
  ////////////////////

  assign cnt_up   = push_o;
  assign cnt_down = rvalid_i;

  always_comb begin
    case ({cnt_up, cnt_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // idle or accept and retire together
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_cnt_in_range : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(DEPTH))
    else $error("outstanding count %0d above %0d", cnt_q, DEPTH);

  // a response needs an earlier accepted request
  a_no_spurious_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n) rvalid_i |-> (cnt_q != '0))
    else $error("rvalid without outstanding transaction");

endmodule

`default_nettype wire

// File: lsu_wb_fifo.sv
// writeback control queue
`default_nettype none
`timescale 1ns/1ps

module lsu_wb_fifo #(
  parameter int DEPTH = 2  // one entry per outstanding transaction
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push_i,   // request accepted on the bus
  input  wire lsu_pkg::wb_ctrl_t entry_i,
  input  wire logic              pop_i,    // response retired
  output lsu_pkg::wb_ctrl_t      head_o,   // oldest entry
  output logic                   full_o,
  output logic                   empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_pkg::wb_ctrl_t mem_q [DEPTH];  // entry storage
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;          // filled entries

  // wraps at DEPTH, so non power of two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);

  ////////////////////
  // pointers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // each response must match an entry pushed at grant
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("writeback queue popped while empty");

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the LSU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lsu -f lsu.f -o tb_lsu_sim &&
  ./obj_dir/tb_lsu_sim | tee /dev/stderr | grep "Finished with no errors" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: tb_lsu.sv
// load/store unit testbench
`default_nettype none
`timescale 1ns/1ps

module tb_lsu;

  localparam int DEPTH      = 2;   // outstanding limit of the DUT
  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 16;
  localparam int MAX_VEC    = 64;
  localparam int NCOL       = 13;  // fields per stimulus line

  // stimulus columns
  localparam int C_WE     = 0;
  localparam int C_TYPE   = 1;
  localparam int C_EXT    = 2;
  localparam int C_OPA    = 3;
  localparam int C_OPB    = 4;
  localparam int C_INCR   = 5;
  localparam int C_WDATA  = 6;
  localparam int C_REGOFF = 7;
  localparam int C_ADDR   = 8;
  localparam int C_BE     = 9;
  localparam int C_BUSW   = 10;
  localparam int C_MEM    = 11;  // word the bus returns
  localparam int C_LOAD   = 12;  // expected register value

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_ex;
  logic        we_ex;
  logic [1:0]  type_ex;
  logic [1:0]  ext_ex;
  logic [31:0] wdata_ex;
  logic [1:0]  regoff_ex;
  logic [31:0] opa_ex;
  logic [31:0] opb_ex;
  logic        useincr_ex;
  logic        gnt;
  logic        rvalid;
  logic [31:0] rdata;
  logic        data_req;
  logic [31:0] data_addr;
  logic        data_we;
  logic [3:0]  data_be;
  logic [31:0] data_wdata;
  logic        ready_ex;
  logic        ready_wb;
  logic        busy;
  logic [31:0] rdata_ex;
  logic        rvalid_ex;

  logic [31:0] vec [MAX_VEC][NCOL];  // stimulus table
  int          n_vec;
  int          n_loads;
  int          loads_seen;
  int          idx;          // line on the execute port
  logic        ex_active;    // request held on the execute port
  logic        accepted;     // address phase done in the sampled cycle
  logic        req_seen;
  int          gnt_wait;     // stalled cycles left before grant
  int          cyc;
  int          last_due;     // cycle of the youngest scheduled response
  int          pend_idx [$];  // accepted lines awaiting rvalid in order
  int          pend_due [$];
  logic        loaded = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

  lsu_top #(.LSU_DEPTH(DEPTH)) lsu_top_inst (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_req_ex_i        (req_ex),
    .data_we_ex_i         (we_ex),
    .data_type_ex_i       (type_ex),
    .data_sign_ext_ex_i   (ext_ex),
    .data_wdata_ex_i      (wdata_ex),
    .data_reg_offset_ex_i (regoff_ex),
    .operand_a_ex_i       (opa_ex),
    .operand_b_ex_i       (opb_ex),
    .addr_useincr_ex_i    (useincr_ex),
    .data_req_o           (data_req),
    .data_gnt_i           (gnt),
    .data_addr_o          (data_addr),
    .data_we_o            (data_we),
    .data_be_o            (data_be),
    .data_wdata_o         (data_wdata),
    .data_rvalid_i        (rvalid),
    .data_rdata_i         (rdata),
    .lsu_ready_ex_o       (ready_ex),
    .lsu_ready_wb_o       (ready_wb),
    .busy_o               (busy),
    .data_rdata_ex_o      (rdata_ex),
    .data_rvalid_ex_o     (rvalid_ex)
  );

  ////////////////////
  // reporting
  ////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("MISMATCH %s got %h expected %h cycle %0d",
                              name, got, exp, cyc));
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic load_stimulus();
    int          fd;
    int          k;
    int          got;
    logic [31:0] field;
    fd = $fopen("lsu_stimulus.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the stimulus file lsu_stimulus.txt");
    end else begin
      n_vec   = 0;
      n_loads = 0;
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        got = 0;
        for (k = 0; k < NCOL; k++) begin
          if ($fscanf(fd, "%h", field) == 1) begin
            vec[n_vec][k] = field;
            got++;
          end
        end
        if (got == NCOL) begin
          if (vec[n_vec][C_WE] == 0) n_loads++;
          n_vec++;
        end else if (got != 0) begin
          fail_run("a stimulus line has missing fields");
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic present_line(input int n);
    req_ex     = 1'b1;
    we_ex      = vec[n][C_WE][0];
    type_ex    = vec[n][C_TYPE][1:0];
    ext_ex     = vec[n][C_EXT][1:0];
    opa_ex     = vec[n][C_OPA];
    opb_ex     = vec[n][C_OPB];
    useincr_ex = vec[n][C_INCR][0];
    wdata_ex   = vec[n][C_WDATA];
    regoff_ex  = vec[n][C_REGOFF][1:0];
  endtask

  // bus model and execute port driven 1 ns after the rising edge
  task automatic drive_cycle();
    if (pend_idx.size() != 0 && pend_due[0] == cyc) begin  // in-order response beat
      rvalid = 1'b1;
      rdata  = vec[pend_idx[0]][C_MEM];
    end else begin
      rvalid = 1'b0;
      rdata  = '0;
    end
    if (accepted) gnt_wait = $urandom_range(0, 2);  // delay for the next request
    else if (req_seen && gnt_wait > 0) gnt_wait--;
    gnt = (gnt_wait == 0);
    if (!ex_active) begin
      if (idx < n_vec && $urandom_range(0, 3) != 0) begin  // idle gap now and then
        present_line(idx);
        ex_active = 1'b1;
      end else begin
        req_ex = 1'b0;
      end
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  // sampled mid-cycle where values are settled for the next edge
  task automatic check_cycle();
    logic exp_req;
    int   j;
    int   due;
    exp_req = ex_active && (pend_idx.size() < DEPTH);  // blocked while DEPTH pending
    check_value("data_req_o", 32'(data_req), 32'(exp_req));
    if (exp_req) begin  // payload held until the grant
      check_value("data_addr_o", data_addr, vec[idx][C_ADDR]);
      check_value("data_be_o", 32'(data_be), vec[idx][C_BE]);
      check_value("data_wdata_o", data_wdata, vec[idx][C_BUSW]);
      check_value("data_we_o", 32'(data_we), vec[idx][C_WE]);
    end
    accepted = exp_req && gnt;
    req_seen = exp_req;
    check_value("lsu_ready_ex_o", 32'(ready_ex), 32'(!ex_active || accepted));
    check_value("busy_o", 32'(busy), 32'(pend_idx.size() != 0 || exp_req));
    check_value("lsu_ready_wb_o", 32'(ready_wb), 32'(pend_idx.size() == 0 || rvalid));
    if (rvalid) begin
      j = pend_idx.pop_front();
      void'(pend_due.pop_front());
      if (vec[j][C_WE] == 0) begin
        check_value("data_rvalid_ex_o", 32'(rvalid_ex), 32'd1);
        check_value("data_rdata_ex_o", rdata_ex, vec[j][C_LOAD]);
        loads_seen++;
      end else begin
        check_value("data_rvalid_ex_o", 32'(rvalid_ex), 32'd0);  // store response
      end
    end else begin
      check_value("data_rvalid_ex_o", 32'(rvalid_ex), 32'd0);
    end
    if (accepted) begin
      due = cyc + $urandom_range(1, 3);
      if (due <= last_due) due = last_due + 1;  // one beat per cycle and in order
      pend_idx.push_back(idx);
      pend_due.push_back(due);
      last_due  = due;
      ex_active = 1'b0;
      idx++;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
    cyc++;
    drive_cycle();
    @(negedge clk);
    check_cycle();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    void'($urandom(49411));
    rst_n      = 1'b0;
    req_ex     = 1'b0;
    we_ex      = 1'b0;
    type_ex    = 2'b00;
    ext_ex     = 2'b00;
    wdata_ex   = '0;
    regoff_ex  = 2'b00;
    opa_ex     = '0;
    opb_ex     = '0;
    useincr_ex = 1'b0;
    gnt        = 1'b0;
    rvalid     = 1'b0;
    rdata      = '0;
    ex_active  = 1'b0;
    accepted   = 1'b0;
    req_seen   = 1'b0;
    idx        = 0;
    cyc        = 0;
    last_due   = -1;
    loads_seen = 0;
    gnt_wait   = 0;
    load_stimulus();
    if (n_vec == 0) fail_run("no stimulus lines were read");
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    gnt_wait = $urandom_range(0, 2);
    gnt      = (gnt_wait == 0);
    @(negedge clk);
    check_cycle();  // idle state right after reset
    while (idx < n_vec || ex_active || pend_idx.size() != 0) begin
      step_cycle();
    end
    repeat (3) begin  // unit idle again once drained
      step_cycle();
    end
    if (loads_seen == n_loads) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run("not every load returned its data");
    end
  end

  // watchdog allows 40 cycles per access on top of reset
  initial begin
    wait (loaded);
    repeat (RST_CYCLES + 40 * n_vec + 10) @(posedge clk);
    fail_run("watchdog expired before all accesses completed");
  end

endmodule

`default_nettype wire
